//--- bench/tb_sieve_pe.sv
// Sieve PE testbench with a command table, reference bitmap model, LFSR stimulus and checks
module tb_sieve_pe;
        timeunit 1ns;
        timeprecision 1ps;

        import sieve_pkg::*;

        localparam int WORD_COUNT   = 64;
        localparam int WORD_INDEX_W = $clog2(WORD_COUNT);
        localparam int BIT_COUNT    = WORD_COUNT * PE_DATA_W;
        localparam int READ_CYCLES  = 3;
        localparam int CLEAR_CYCLES = WORD_COUNT + 2;
        localparam int DONE_TIMEOUT = 20000;                  // Clocks per command

        // Stimulus row whose expected_cycles is zero when the latency is not fixed
        typedef struct packed {
                pe_command_e command;
                pe_args_t    args;
                logic [15:0] expected_cycles;
                logic        read_back;                         // Compare every word afterwards
        } row_t;

        logic                 clock = 1'b0;
        logic                 reset_n;
        logic                 start;
        pe_command_e          command;
        pe_args_t             args;
        logic [PE_DATA_W-1:0] read_data;
        logic                 command_done;

        logic [PE_DATA_W-1:0] model [WORD_COUNT];               // Expected bitmap
        logic [15:0]          lfsr_state = 16'd17568;
        row_t                 table_rows [$];

        sieve_pe #(
                .WORD_COUNT (WORD_COUNT)
        ) u_sieve_pe (
                .clock        (clock),
                .reset_n      (reset_n),
                .start        (start),
                .command      (command),
                .args         (args),
                .read_data    (read_data),
                .command_done (command_done)
        );

        always #5 clock = ~clock;

        // Taps for x^16 + x^14 + x^13 + x^11 + 1
        function automatic logic [15:0] lfsr_step(input logic [15:0] state);
                logic feedback;
                feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
                return {state[14:0], feedback};
        endfunction

        task automatic draw_bits(input int width, output int value);
                value = 0;
                for (int i = 0; i < width; i++) begin
                        lfsr_state = lfsr_step(lfsr_state);   // One step per bit
                        value      = (value << 1) | int'(lfsr_state[0]);
                end
        endtask

        function automatic pe_args_t make_args(input int first, input int last, input int step_a,
                                               input int step_b, input int address);
                pe_args_t result;
                result.first_offset = PE_OFFSET_W'(first);
                result.last_offset  = PE_OFFSET_W'(last);
                result.step_a       = PE_OFFSET_W'(step_a);
                result.step_b       = PE_OFFSET_W'(step_b);
                result.read_address = PE_ADDRESS_W'(address);
                return result;
        endfunction

        task automatic add_row(input pe_command_e row_command, input pe_args_t row_args,
                               input int cycles, input logic read_back);
                row_t row;
                row.command         = row_command;
                row.args            = row_args;
                row.expected_cycles = 16'(cycles);
                row.read_back       = read_back;
                table_rows.push_back(row);
        endtask

        task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                                   input string what);
                if (actual !== expected) begin
                        $display("CHECK FAILED at time %0t: %s, got %h, expected %h",
                                 $time, what, actual, expected);
                        $display("sim failed");
                        $fatal(1);
                end
        endtask

        // Reference rule for each command
        task automatic apply_rule(input row_t row);
                int                      offset;
                logic                    use_b;
                logic [WORD_INDEX_W-1:0] word_index;
                logic [PE_BIT_W-1:0]     bit_index;
                case (row.command)
                        CLEAR: begin
                                for (int w = 0; w < WORD_COUNT; w++) begin
                                        model[WORD_INDEX_W'(w)] = '0;
                                end
                        end
                        COMPUTE: begin
                                offset = int'(row.args.first_offset);
                                use_b  = 1'b0;                   // step_a first
                                while (offset <= int'(row.args.last_offset)) begin
                                        word_index = WORD_INDEX_W'(offset >> PE_BIT_W);
                                        bit_index  = PE_BIT_W'(offset);
                                        model[word_index][bit_index] = 1'b1;
                                        if (use_b) begin
                                                offset = offset + int'(row.args.step_b);
                                        end else begin
                                                offset = offset + int'(row.args.step_a);
                                        end
                                        use_b = !use_b;
                                end
                        end
                        default: ;                               // READ leaves the bitmap alone
                endcase
        endtask

        task automatic wait_for_done(output int cycles);
                cycles = 0;
                do begin
                        @(negedge clock);
                        cycles++;
                end while (!command_done && cycles < DONE_TIMEOUT);
                if (!command_done) begin
                        $display("Timeout: command_done did not pulse within %0d clocks",
                                 DONE_TIMEOUT);
                        $display("sim failed");
                        $fatal(1);
                end
        endtask

        task automatic run_command(input row_t row);
                int cycles;
                @(negedge clock);
                command = row.command;
                args    = row.args;
                start   = 1'b1;
                wait_for_done(cycles);
                start = 1'b0;                                    // Low for a clock before the next one
                apply_rule(row);
                if (row.expected_cycles != 0) begin
                        check_value(32'(cycles), 32'(row.expected_cycles),
                                    $sformatf("%s latency", row.command.name()));
                end
                if (row.command == READ) begin
                        check_value(read_data, model[row.args.read_address[WORD_INDEX_W-1:0]],
                                    $sformatf("word %0d", row.args.read_address));
                end
        endtask

        task automatic read_back_all();
                row_t row;
                for (int w = 0; w < WORD_COUNT; w++) begin
                        row.command         = READ;
                        row.args            = make_args(0, 0, 1, 1, w);
                        row.expected_cycles = 16'(READ_CYCLES);
                        row.read_back       = 1'b0;
                        run_command(row);
                end
        endtask

        task automatic build_table();
                int first;
                int span;
                int last;
                int step_a;
                int step_b;
                add_row(CLEAR, make_args(0, 0, 1, 1, 0), CLEAR_CYCLES, 1'b0);
                add_row(READ, make_args(0, 0, 1, 1, 0), READ_CYCLES, 1'b0);
                add_row(READ, make_args(0, 0, 1, 1, 17), READ_CYCLES, 1'b0);
                add_row(READ, make_args(0, 0, 1, 1, 63), READ_CYCLES, 1'b0);
                add_row(COMPUTE, make_args(3, 700, 7, 7, 0), 0, 1'b1);       // Equal steps
                add_row(COMPUTE, make_args(10, 1500, 5, 13, 0), 0, 1'b1);    // Alternating steps
                add_row(COMPUTE, make_args(100, 900, 11, 3, 0), 0, 1'b0);    // Overlaps both
                add_row(COMPUTE, make_args(800, 200, 4, 4, 0), 0, 1'b1);     // Empty walk
                add_row(READ, make_args(0, 0, 1, 1, 20), READ_CYCLES, 1'b0);
                add_row(CLEAR, make_args(0, 0, 1, 1, 0), CLEAR_CYCLES, 1'b1);

                // Random walks kept inside the 64 word bitmap
                for (int r = 0; r < 3; r++) begin
                        draw_bits(11, first);
                        draw_bits(9, span);
                        draw_bits(6, step_a);
                        draw_bits(6, step_b);
                        last = first + span;
                        if (last >= BIT_COUNT) begin
                                last = BIT_COUNT - 1;
                        end
                        add_row(COMPUTE, make_args(first, last, step_a + 1, step_b + 1, 0), 0,
                                r == 2);
                end
        endtask

        initial begin
                reset_n = 1'b0;
                start   = 1'b0;
                command = COMPUTE;
                args    = '0;
                repeat (16) @(negedge clock);
                reset_n = 1'b1;
                check_value(32'(command_done), 32'd0, "command_done after reset");
                check_value(read_data, 32'd0, "read_data after reset");

                build_table();
                foreach (table_rows[i]) begin
                        run_command(table_rows[i]);
                        if (table_rows[i].read_back) begin
                                read_back_all();
                        end
                end

                $display("sim passed");
                $finish;
        end

endmodule

//--- rtl/bitmap_ram.sv
// Inferred simple dual-port bitmap RAM with one write port and a registered read port
module bitmap_ram #(
        parameter int WORD_COUNT = 512
) (
        input  logic                                 clock,
        input  sieve_pkg::ram_write_t                ram_write,
        input  logic [sieve_pkg::PE_ADDRESS_W-1:0]   ram_read_address,
        output logic [sieve_pkg::PE_DATA_W-1:0]      ram_read_data
);
        import sieve_pkg::*;

        localparam int INDEX_W = (WORD_COUNT > 1) ? $clog2(WORD_COUNT) : 1;

        logic [PE_DATA_W-1:0] memory [WORD_COUNT];

        always_ff @(posedge clock) begin
                if (ram_write.enable) begin
                        memory[ram_write.address[INDEX_W-1:0]] <= ram_write.data;
                end
                ram_read_data <= memory[ram_read_address[INDEX_W-1:0]];   // Read-first
        end

endmodule

//--- rtl/bitmap_writer.sv
// Bitmap writer merging marks into a word mask by read-modify-write and muxing the RAM ports
module bitmap_writer (
        input  logic                                 clock,
        input  logic                                 reset_n,
        input  logic                                 compute_go,
        input  logic                                 read_go,
        input  logic [sieve_pkg::PE_ADDRESS_W-1:0]   read_address,
        input  sieve_pkg::pe_mark_t                  mark,
        output logic                                 mark_accept,
        input  logic                                 walk_end,
        input  sieve_pkg::ram_write_t                clear_write,
        output sieve_pkg::ram_write_t                ram_write,
        output logic [sieve_pkg::PE_ADDRESS_W-1:0]   ram_read_address,
        input  logic [sieve_pkg::PE_DATA_W-1:0]      ram_read_data,
        output logic                                 compute_end,
        output logic                                 read_valid
);
        import sieve_pkg::*;

        typedef enum logic [1:0] {
                writer_idle,
                writer_seek,    // Issue the read of the next word
                writer_merge    // Collects marks on the fetched word
        } writer_state_e;

        writer_state_e           state;
        logic [PE_ADDRESS_W-1:0] open_address;
        logic [PE_DATA_W-1:0]    mask;
        logic [PE_DATA_W-1:0]    mark_bit;
        logic                    same_word;
        logic                    flush;
        ram_write_t              merge_write;

        assign mark_bit    = PE_DATA_W'(1) << mark.bit_index;
        assign same_word   = mark.word_address == open_address;
        assign mark_accept = (state == writer_merge) && same_word;

        // Write back when the walk leaves the word or ends
        assign flush = (state == writer_merge) && !(mark.valid && same_word);

        assign merge_write.enable  = flush;
        assign merge_write.address = open_address;
        assign merge_write.data    = ram_read_data | mask;

        // Merge and clear never run together
        assign ram_write = merge_write.enable ? merge_write : clear_write;

        always_comb begin
                if (state == writer_seek) begin
                        ram_read_address = mark.word_address;
                end else if (read_go) begin
                        ram_read_address = read_address;
                end else begin
                        ram_read_address = open_address;    // Keeps the fetched word on the output
                end
        end

        always_ff @(posedge clock) begin
                if (!reset_n) begin
                        state       <= writer_idle;
                        compute_end <= 1'b0;
                        read_valid  <= 1'b0;
                end else begin
                        read_valid  <= read_go;
                        compute_end <= 1'b0;

                        case (state)
                                writer_idle: begin
                                        if (compute_go) begin
                                                state <= writer_seek;
                                        end
                                end
                                writer_seek: begin
                                        if (mark.valid) begin
                                                state <= writer_merge;
                                        end else if (walk_end) begin
                                                state       <= writer_idle;   // Empty walk
                                                compute_end <= 1'b1;
                                        end
                                end
                                writer_merge: begin
                                        if (flush) begin
                                                if (walk_end) begin
                                                        state       <= writer_idle;
                                                        compute_end <= 1'b1;
                                                end else begin
                                                        state <= writer_seek;
                                                end
                                        end
                                end
                                default: state <= writer_idle;
                        endcase
                end
        end

        // Open word and its pending bits
        always_ff @(posedge clock) begin
                if (state == writer_seek) begin
                        open_address <= mark.word_address;
                        mask         <= '0;
                end else if (mark.valid && mark_accept) begin
                        mask <= mask | mark_bit;
                end
        end

endmodule

//--- rtl/clear_sweeper.sv
// Clear sweeper writing zero to every bitmap word, one address per cycle
module clear_sweeper #(
        parameter int WORD_COUNT = 512
) (
        input  logic                   clock,
        input  logic                   reset_n,
        input  logic                   clear_go,
        output sieve_pkg::ram_write_t  clear_write,
        output logic                   clear_end
);
        import sieve_pkg::*;

        logic                    active;
        logic [PE_ADDRESS_W-1:0] address;
        logic                    last_word;

        assign last_word = address == PE_ADDRESS_W'(WORD_COUNT - 1);

        assign clear_write.enable  = active;
        assign clear_write.address = address;
        assign clear_write.data    = '0;
        assign clear_end           = active && last_word;   // With the last write

        always_ff @(posedge clock) begin
                if (!reset_n) begin
                        active  <= 1'b0;
                        address <= '0;
                end else if (clear_go) begin
                        active  <= 1'b1;
                        address <= '0;
                end else if (active) begin
                        if (last_word) begin
                                active <= 1'b0;
                        end else begin
                                address <= address + 1'b1;
                        end
                end
        end

endmodule

//--- rtl/command_sequencer.sv
// Start edge detection, command decode into go strobes, command_done and read result register
module command_sequencer (
        input  logic                              clock,
        input  logic                              reset_n,
        input  logic                              start,
        input  sieve_pkg::pe_command_e            command,
        output logic                              compute_go,
        output logic                              clear_go,
        output logic                              read_go,
        input  logic                              compute_end,
        input  logic                              clear_end,
        input  logic                              read_valid,
        input  logic [sieve_pkg::PE_DATA_W-1:0]   ram_read_data,
        output logic [sieve_pkg::PE_DATA_W-1:0]   read_data,
        output logic                              command_done
);
        import sieve_pkg::*;

        logic        start_q;
        logic        start_edge;
        logic        busy;
        pe_command_e running;   // Command in flight
        logic        end_hit;

        assign start_edge = start && !start_q;

        // Only the end event of the running command counts
        always_comb begin
                case (running)
                        COMPUTE: end_hit = compute_end;
                        CLEAR:   end_hit = clear_end;
                        READ:    end_hit = read_valid;
                        default: end_hit = 1'b0;
                endcase
        end

        always_ff @(posedge clock) begin
                if (!reset_n) begin
                        start_q      <= 1'b0;
                        compute_go   <= 1'b0;
                        clear_go     <= 1'b0;
                        read_go      <= 1'b0;
                        busy         <= 1'b0;
                        running      <= COMPUTE;
                        command_done <= 1'b0;
                        read_data    <= '0;
                end else begin
                        start_q      <= start;
                        compute_go   <= start_edge && (command == COMPUTE);
                        clear_go     <= start_edge && (command == CLEAR);
                        read_go      <= start_edge && (command == READ);
                        command_done <= busy && end_hit;   // One cycle after the end event

                        if (start_edge) begin
                                busy    <= 1'b1;
                                running <= command;        // Args and command sampled here
                        end else if (busy && end_hit) begin
                                busy <= 1'b0;
                        end

                        if (read_valid) begin
                                read_data <= ram_read_data; // Held until the next read
                        end
                end
        end

endmodule

//--- rtl/offset_walker.sv
// Alternating-step offset walker presenting one mark per offset with back-pressure
module offset_walker (
        input  logic                 clock,
        input  logic                 reset_n,
        input  logic                 compute_go,
        input  sieve_pkg::pe_args_t  args,
        output sieve_pkg::pe_mark_t  mark,
        input  logic                 mark_accept,
        output logic                 walk_end
);
        import sieve_pkg::*;

        logic [PE_OFFSET_W:0]   offset;      // Extra top bit so the final add cannot wrap
        logic [PE_OFFSET_W-1:0] step;
        logic                   use_step_b;
        logic                   active;      // Loaded and not yet past the end
        logic                   past_last;   // Current offset beyond last_offset
        logic                   advance;

        assign step      = use_step_b ? args.step_b : args.step_a;
        assign past_last = offset > {1'b0, args.last_offset};
        assign walk_end  = !active || past_last;   // Held until the next load
        assign advance   = mark.valid && mark_accept;

        // Split the offset into word and bit
        assign mark.valid        = active && !past_last;
        assign mark.word_address = offset[PE_OFFSET_W-1:PE_BIT_W];
        assign mark.bit_index    = offset[PE_BIT_W-1:0];

        always_ff @(posedge clock) begin
                if (!reset_n) begin
                        offset     <= '0;
                        use_step_b <= 1'b0;
                        active     <= 1'b0;
                end else if (compute_go) begin
                        offset     <= {1'b0, args.first_offset};
                        use_step_b <= 1'b0;                    // step_a comes first
                        active     <= 1'b1;
                end else begin
                        if (advance) begin
                                offset     <= offset + {1'b0, step};
                                use_step_b <= !use_step_b;
                        end

                        // Nothing more to present once past last_offset
                        if (past_last) begin
                                active <= 1'b0;
                        end
                end
        end

endmodule

//--- rtl/sieve_pe.sv
// Sieve processing element top level, connecting the sequencer, walker, sweeper, writer and RAM
module sieve_pe #(
        parameter int WORD_COUNT = 512
) (
        input  logic                              clock,
        input  logic                              reset_n,
        input  logic                              start,
        input  sieve_pkg::pe_command_e            command,
        input  sieve_pkg::pe_args_t               args,
        output logic [sieve_pkg::PE_DATA_W-1:0]   read_data,
        output logic                              command_done
);
        import sieve_pkg::*;

        logic                    compute_go;
        logic                    clear_go;
        logic                    read_go;
        logic                    compute_end;
        logic                    clear_end;
        logic                    read_valid;
        logic                    walk_end;
        logic                    mark_accept;
        pe_mark_t                mark;
        ram_write_t              clear_write;
        ram_write_t              ram_write;
        logic [PE_ADDRESS_W-1:0] ram_read_address;
        logic [PE_DATA_W-1:0]    ram_read_data;

        command_sequencer u_command_sequencer (
                .clock         (clock),
                .reset_n       (reset_n),
                .start         (start),
                .command       (command),
                .compute_go    (compute_go),
                .clear_go      (clear_go),
                .read_go       (read_go),
                .compute_end   (compute_end),
                .clear_end     (clear_end),
                .read_valid    (read_valid),
                .ram_read_data (ram_read_data),
                .read_data     (read_data),
                .command_done  (command_done)
        );

        offset_walker u_offset_walker (
                .clock       (clock),
                .reset_n     (reset_n),
                .compute_go  (compute_go),
                .args        (args),
                .mark        (mark),
                .mark_accept (mark_accept),
                .walk_end    (walk_end)
        );

        clear_sweeper #(
                .WORD_COUNT (WORD_COUNT)
        ) u_clear_sweeper (
                .clock       (clock),
                .reset_n     (reset_n),
                .clear_go    (clear_go),
                .clear_write (clear_write),
                .clear_end   (clear_end)
        );

        bitmap_writer u_bitmap_writer (
                .clock            (clock),
                .reset_n          (reset_n),
                .compute_go       (compute_go),
                .read_go          (read_go),
                .read_address     (args.read_address),  // Host holds args for the whole read
                .mark             (mark),
                .mark_accept      (mark_accept),
                .walk_end         (walk_end),
                .clear_write      (clear_write),
                .ram_write        (ram_write),
                .ram_read_address (ram_read_address),
                .ram_read_data    (ram_read_data),
                .compute_end      (compute_end),
                .read_valid       (read_valid)
        );

        bitmap_ram #(
                .WORD_COUNT (WORD_COUNT)
        ) u_bitmap_ram (
                .clock            (clock),
                .ram_write        (ram_write),
                .ram_read_address (ram_read_address),
                .ram_read_data    (ram_read_data)
        );

endmodule

//--- rtl/sieve_pkg.sv
// Sieve PE widths, command opcode enum and the packed structs shared by all blocks
package sieve_pkg;

        localparam int PE_ADDRESS_W = 9;                        // Bitmap word address
        localparam int PE_DATA_W    = 32;                       // Bitmap word
        localparam int PE_BIT_W     = 5;                        // Bit index inside a word
        localparam int PE_OFFSET_W  = PE_ADDRESS_W + PE_BIT_W;  // Bit offset into the bitmap

        // Host command opcode
        typedef enum logic [1:0] {
                COMPUTE = 2'd0,
                CLEAR   = 2'd1,
                READ    = 2'd2
        } pe_command_e;

        // Command arguments the host holds while the command runs
        typedef struct packed {
                logic [PE_OFFSET_W-1:0]  first_offset;
                logic [PE_OFFSET_W-1:0]  last_offset;   // Inclusive
                logic [PE_OFFSET_W-1:0]  step_a;        // Taken first
                logic [PE_OFFSET_W-1:0]  step_b;
                logic [PE_ADDRESS_W-1:0] read_address;
        } pe_args_t;

        // One bit to set as word address and bit index
        typedef struct packed {
                logic                    valid;
                logic [PE_ADDRESS_W-1:0] word_address;
                logic [PE_BIT_W-1:0]     bit_index;
        } pe_mark_t;

        // One write on the RAM write port
        typedef struct packed {
                logic                    enable;
                logic [PE_ADDRESS_W-1:0] address;
                logic [PE_DATA_W-1:0]    data;
        } ram_write_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the sieve PE testbench with Verilator, then search the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module tb_sieve_pe -f sieve_pe.f -o tb_sieve_pe \
        || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_sieve_pe > sim.log 2>&1 || echo "Simulation exited with an error status"

test -f sim.log || { echo "No simulation log found"; exit 1; }

grep -q "sim failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } || { echo "PASS"; exit 0; }

//--- sieve_pe.f
rtl/sieve_pkg.sv
rtl/bitmap_ram.sv
rtl/clear_sweeper.sv
rtl/offset_walker.sv
rtl/bitmap_writer.sv
rtl/command_sequencer.sv
rtl/sieve_pe.sv
bench/tb_sieve_pe.sv
